// File: all.f
+incdir+verification
src/lfsr_taps_pkg.sv
src/prbs_bist_pkg.sv
src/shifter_lfsr.sv
src/prbs_checker.sv
src/prbs_bist_ctrl.sv
src/prbs_bist_top.sv
verification/prbs_bist_tb.sv

// File: verification/prbs_bist_ref.svh
`ifndef PRBS_BIST_REF_SVH
`define PRBS_BIST_REF_SVH

////////////////////////////////////////////////////////////
// polynomial

// position n sits at bit n-1
function automatic logic [31:0] tap_mask_for(input int width);
    case (width)
        8:       return 32'h0000_00B8;  // taps 8 6 5 4
        16:      return 32'h0000_D008;  // taps 16 15 13 4
        default: return 32'h0;
    endcase
endfunction

function automatic logic [31:0] width_mask(input int width);
    if (width >= 32) begin
        return '1;
    end
    return (32'h1 << width) - 1;
endfunction

// package lookup decoded slot by slot, empty slots skipped
function automatic bit taps_agree(input int width);
    lfsr_taps_pkg::tap_vec_t vec;
    logic [31:0]             mask;
    int                      pos;
    vec  = lfsr_taps_pkg::max_len_taps(width);
    mask = '0;
    for (int s = 0; s < lfsr_taps_pkg::TAP_COUNT; s++) begin
        pos = vec[s*lfsr_taps_pkg::TAP_INDEX_WIDTH +: lfsr_taps_pkg::TAP_INDEX_WIDTH];
        if (pos > 0 && pos <= 32) begin
            mask[pos-1] = 1'b1;
        end
    end
    return (mask == tap_mask_for(width)) && (mask != '0);
endfunction

////////////////////////////////////////////////////////////
// stream model

// shift left, xnor of the tapped bits enters at bit 0
function automatic logic [31:0] next_state(input logic [31:0] state, input int width);
    logic fb;
    fb = ~^(state & tap_mask_for(width));
    return ((state << 1) | 32'(fb)) & width_mask(width);
endfunction

// tx bit k is bit 0 after shift k+1
task automatic build_stream(input logic [31:0] seed, input int width, input int n,
                            output bit bits [$]);
    logic [31:0] state;
    bits.delete();
    state = seed & width_mask(width);
    for (int k = 0; k < n; k++) begin
        state = next_state(state, width);
        bits.push_back(state[0]);
    end
endtask

// first 1-based bit after which the state is the seed again, 0 if beyond the run
function automatic int period_of(input logic [31:0] seed, input int width, input int run_len);
    logic [31:0] state;
    state = seed & width_mask(width);
    for (int k = 1; k <= run_len; k++) begin
        state = next_state(state, width);
        if (state == (seed & width_mask(width))) begin
            return k;
        end
    end
    return 0;
endfunction

`endif

// File: verification/prbs_bist_tb.sv
`timescale 1ns/1ns

module prbs_bist_tb;

    localparam int WIDTH      = 8;
    localparam int CLK_PERIOD = 100;
    localparam int RST_CYCLES = 8;
    localparam int FLIP_DEPTH = 1024;  // longest run must fit
    localparam int SETTLE     = 4;     // checker count lags done by a few cycles

    typedef struct packed {
        logic [31:0]      seed;
        logic             rand_seed;   // draw seed from $random instead
        logic [19:0]      run_len;
        logic [3:0][31:0] flips;       // tx bit indices to corrupt, -1 unused
        logic             mid_start;   // extra start pulse halfway through
        logic [19:0]      exp_period;
    } tb_case_t;

    logic                        i_clk      = 1'b0;
    logic                        i_rst_n    = 1'b0;
    logic                        i_start    = 1'b0;
    prbs_bist_pkg::bist_cfg_t    i_cfg      = '0;
    logic                        i_rx_bit   = 1'b0;
    logic                        i_rx_valid = 1'b0;
    logic                        o_tx_bit;
    logic                        o_tx_valid;
    prbs_bist_pkg::bist_status_t o_status;
    logic                        o_test_done;

    tb_case_t case_table [$];
    bit       table_ready = 1'b0;
    logic     flip_mask [FLIP_DEPTH];
    int       lb_idx      = 0;        // tx bit index on the loopback
    int       seed_var    = 32'h2811;
    int       failures    = 0;

    `include "prbs_bist_ref.svh"

    always #(CLK_PERIOD/2) i_clk = ~i_clk;

    prbs_bist_top #(
        .WIDTH (WIDTH)
    ) prbs_bist_top_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .i_cfg       (i_cfg),
        .i_rx_bit    (i_rx_bit),
        .i_rx_valid  (i_rx_valid),
        .o_tx_bit    (o_tx_bit),
        .o_tx_valid  (o_tx_valid),
        .o_status    (o_status),
        .o_test_done (o_test_done)
    );

    ////////////////////////////////////////////////////////////
    // channel: one register, bit flips by tx index

    always @(posedge i_clk) begin
        if (!i_rst_n) begin
            lb_idx     <= 0;
            i_rx_bit   <= 1'b0;
            i_rx_valid <= 1'b0;
        end else begin
            if (!o_status.busy) begin
                lb_idx <= 0;  // next test restarts at bit 0
            end else if (o_tx_valid) begin
                lb_idx <= lb_idx + 1;
            end
            i_rx_valid <= o_tx_valid;
            i_rx_bit   <= o_tx_bit ^ (o_tx_valid && lb_idx < FLIP_DEPTH && flip_mask[lb_idx]);
        end
    end

    ////////////////////////////////////////////////////////////
    // error reporting

    task automatic mismatch_stop(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        failures++;
        $display("Fail %s: got 0x%0h, expected 0x%0h at %0t ns", name, got, exp, $time);
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic protocol_stop(input string what);
        failures++;
        $display("Error: %s at %0t ns", what, $time);
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    ////////////////////////////////////////////////////////////
    // case table

    task automatic add_case(input logic [31:0] seed, input bit rand_seed, input int run_len,
                            input int f0, input int f1, input int f2, input int f3,
                            input bit mid_start, input int exp_period);
        tb_case_t tc;
        tc.seed       = seed;
        tc.rand_seed  = rand_seed;
        tc.run_len    = run_len;
        tc.flips      = {f3, f2, f1, f0};  // slot 0 low
        tc.mid_start  = mid_start;
        tc.exp_period = exp_period;
        case_table.push_back(tc);
    endtask

    task automatic load_case_table();
        //       seed           rnd run  flips                 mid period
        add_case(32'h0000_0001, 0,  300, -1,  -1,  -1,  -1,  0,  255);
        add_case(32'hDEAD_BEA5, 0,  100, 20,  57,  -1,  -1,  0,  0);    // upper bits unused
        add_case(32'h0000_0000, 1,  300, 8,   100, 299, -1,  0,  255);  // last bit flipped
        add_case(32'h0000_0000, 1,  120, -1,  -1,  -1,  -1,  1,  0);
        add_case(32'h0000_003C, 0,  260, 9,   10,  11,  200, 1,  255);  // burst of three
        add_case(32'h0000_0000, 0,  256, 8,   -1,  -1,  -1,  0,  255);  // zero is legal for xnor
        add_case(32'h0000_0000, 1,  40,  39,  -1,  -1,  -1,  0,  0);
    endtask

    task automatic check_idle();
        assert (o_tx_valid === 1'b0) else mismatch_stop("o_tx_valid", o_tx_valid, 0);
        assert (o_test_done === 1'b0) else mismatch_stop("o_test_done", o_test_done, 0);
        assert (o_status.busy === 1'b0) else mismatch_stop("o_status.busy", o_status.busy, 0);
        assert (o_status.locked === 1'b0) else mismatch_stop("o_status.locked", o_status.locked, 0);
        assert (o_status.err_count === '0)
            else mismatch_stop("o_status.err_count", o_status.err_count, 0);
        assert (o_status.period === '0) else mismatch_stop("o_status.period", o_status.period, 0);
    endtask

    ////////////////////////////////////////////////////////////
    // one test: start, follow the stream, check status

    task automatic run_case(input int idx);
        tb_case_t                 tc;
        logic [31:0]              seed;
        bit                       exp_bits [$];
        int                       exp_period;
        int                       exp_errors;
        int                       sent;
        int                       cycles;
        bit                       finished;
        bit                       mid_sent;
        logic                     want_start;
        tc   = case_table[idx];
        seed = tc.seed;
        if (tc.rand_seed) begin
            seed = $random(seed_var);
            if (&seed[WIDTH-1:0]) begin
                seed[0] = 1'b0;  // all ones is the xnor lock-up state
            end
        end
        build_stream(seed, WIDTH, tc.run_len, exp_bits);
        exp_period = period_of(seed, WIDTH, tc.run_len);
        assert (exp_period == tc.exp_period)
            else mismatch_stop("reference period", exp_period, tc.exp_period);
        exp_errors = 0;
        for (int i = 0; i < FLIP_DEPTH; i++) begin
            flip_mask[i] = 1'b0;
        end
        for (int f = 0; f < 4; f++) begin
            if (int'(tc.flips[f]) >= WIDTH && int'(tc.flips[f]) < int'(tc.run_len)) begin
                flip_mask[tc.flips[f]] = 1'b1;  // window bits would only shift the seed
                exp_errors++;
            end
        end

        @(posedge i_clk);
        i_cfg.seed    <= seed;
        i_cfg.run_len <= tc.run_len;
        i_start       <= 1'b1;
        sent     = 0;
        cycles   = 0;
        finished = 1'b0;
        mid_sent = 1'b0;
        while (!finished) begin
            @(negedge i_clk);
            cycles++;
            if (o_tx_valid) begin
                assert (sent < int'(tc.run_len))
                    else protocol_stop("more bits transmitted than the run length");
                assert (o_tx_bit == exp_bits[sent]) else mismatch_stop("o_tx_bit", o_tx_bit,
                                                                       exp_bits[sent]);
                assert (o_status.busy) else protocol_stop("o_tx_valid high while not busy");
                sent++;
            end
            if (o_test_done) begin
                assert (sent == int'(tc.run_len)) else mismatch_stop("tx bit count", sent,
                                                                     tc.run_len);
                assert (!o_status.busy) else protocol_stop("busy still high at test done");
                finished = 1'b1;
            end
            assert (cycles <= int'(tc.run_len) + 20)
                else protocol_stop("o_test_done never pulsed");
            want_start = 1'b0;
            if (tc.mid_start && !mid_sent && sent == int'(tc.run_len) / 2) begin
                want_start = 1'b1;  // must be ignored while busy
                mid_sent   = 1'b1;
            end
            @(posedge i_clk);
            i_start <= want_start;
        end

        // no second done, no restart, then the counts have settled
        repeat (SETTLE) begin
            @(negedge i_clk);
            assert (!o_test_done) else protocol_stop("o_test_done pulsed twice");
            assert (!o_tx_valid) else protocol_stop("o_tx_valid high after test done");
            assert (!o_status.busy) else protocol_stop("test restarted after mid-run start");
        end
        assert (o_status.locked === 1'b1) else mismatch_stop("o_status.locked",
                                                             o_status.locked, 1);
        assert (o_status.err_count == exp_errors)
            else mismatch_stop("o_status.err_count", o_status.err_count, exp_errors);
        assert (o_status.period == exp_period)
            else mismatch_stop("o_status.period", o_status.period, exp_period);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence and watchdog

    initial begin
        for (int i = 0; i < FLIP_DEPTH; i++) begin
            flip_mask[i] = 1'b0;
        end
        load_case_table();
        table_ready = 1'b1;
        assert (taps_agree(WIDTH)) else protocol_stop("package taps differ from reference taps");
        repeat (RST_CYCLES) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(negedge i_clk);
        check_idle();
        for (int c = 0; c < case_table.size(); c++) begin
            run_case(c);
        end
        if (failures == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("** FAIL **");
            $fatal(1, "checks failed");
        end
    end

    initial begin
        longint limit;
        wait (table_ready);
        limit = 0;
        foreach (case_table[i]) begin
            limit += case_table[i].run_len + 50;  // start, settle and gaps fit in 50
        end
        #(limit * CLK_PERIOD);
        $display("Error: watchdog expired after %0d cycles", limit);
        $display("** FAIL **");
        $fatal(1, "watchdog");
    end

endmodule : prbs_bist_tb

// File: src/prbs_bist_top.sv
`timescale 1ns/1ns

// prbs bist for one lane: sequencer, tx generator, rx checker
module prbs_bist_top #(
    parameter int WIDTH = 8
) (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_start,
    input  prbs_bist_pkg::bist_cfg_t    i_cfg,
    input  logic                        i_rx_bit,     // looped back from the channel
    input  logic                        i_rx_valid,
    output logic                        o_tx_bit,
    output logic                        o_tx_valid,
    output prbs_bist_pkg::bist_status_t o_status,
    output logic                        o_test_done
);

    localparam int ERR_W = prbs_bist_pkg::ERR_COUNT_WIDTH;
    localparam lfsr_taps_pkg::tap_vec_t TAPS = lfsr_taps_pkg::max_len_taps(WIDTH);

    // tap table and seed field cover 3..32
    if (WIDTH < 3 || WIDTH > 32) begin : g_width_range
        $error("prbs_bist_top WIDTH out of tap table range");
    end

    logic             gen_enable;
    logic             gen_seed_load;
    logic             gen_done;
    logic [WIDTH-1:0] gen_state;
    logic             chk_clear;
    logic             chk_locked;
    logic [ERR_W-1:0] chk_err_count;

    ////////////////////////////////////////////////////////////
    // sequencer

    prbs_bist_ctrl #(
        .WIDTH (WIDTH)
    ) ctrl_inst (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_start         (i_start),
        .i_cfg           (i_cfg),
        .i_lfsr_done     (gen_done),
        .i_locked        (chk_locked),
        .i_err_count     (chk_err_count),
        .o_gen_enable    (gen_enable),
        .o_gen_seed_load (gen_seed_load),
        .o_tx_valid      (o_tx_valid),
        .o_chk_clear     (chk_clear),
        .o_test_done     (o_test_done),
        .o_status        (o_status)
    );

    ////////////////////////////////////////////////////////////
    // tx generator

    shifter_lfsr #(
        .WIDTH           (WIDTH),
        .TAP_INDEX_WIDTH (lfsr_taps_pkg::TAP_INDEX_WIDTH),
        .TAP_COUNT       (lfsr_taps_pkg::TAP_COUNT)
    ) gen_lfsr_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_enable    (gen_enable),
        .i_seed_load (gen_seed_load),
        .i_seed_data (i_cfg.seed[WIDTH-1:0]),
        .i_taps      (TAPS),
        .o_lfsr_out  (gen_state),
        .o_lfsr_done (gen_done)
    );

    assign o_tx_bit = gen_state[0];  // newest feedback bit

    ////////////////////////////////////////////////////////////
    // rx checker

    prbs_checker #(
        .WIDTH (WIDTH)
    ) checker_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_clear     (chk_clear),
        .i_rx_bit    (i_rx_bit),
        .i_rx_valid  (i_rx_valid),
        .i_taps      (TAPS),         // same polynomial as tx
        .o_locked    (chk_locked),
        .o_err_count (chk_err_count)
    );

endmodule : prbs_bist_top

// File: src/prbs_bist_ctrl.sv
`timescale 1ns/1ns

// test sequencer: idle -> load seed -> run N shifts -> idle
module prbs_bist_ctrl #(
    parameter int WIDTH = 8
) (
    input  logic                                      i_clk,
    input  logic                                      i_rst_n,
    input  logic                                      i_start,       // one-cycle pulse
    input  prbs_bist_pkg::bist_cfg_t                  i_cfg,
    input  logic                                      i_lfsr_done,   // gen state == seed
    input  logic                                      i_locked,
    input  logic [prbs_bist_pkg::ERR_COUNT_WIDTH-1:0] i_err_count,
    output logic                                      o_gen_enable,
    output logic                                      o_gen_seed_load,
    output logic                                      o_tx_valid,
    output logic                                      o_chk_clear,
    output logic                                      o_test_done,   // one-cycle pulse
    output prbs_bist_pkg::bist_status_t               o_status
);

    localparam int CNT_W = prbs_bist_pkg::MAX_RUN_BITS;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_RUN
    } state_t;

    state_t           state_q;
    logic [CNT_W-1:0] sent_q;          // shifts done in this run
    logic [CNT_W-1:0] period_q;
    logic             period_found_q;
    logic             done_q;
    logic             busy;
    logic             more_bits;       // run length not reached yet

    ////////////////////////////////////////////////////////////
    // control decode

    assign busy            = (state_q != ST_IDLE);
    assign more_bits       = (sent_q != i_cfg.run_len);
    assign o_gen_seed_load = (state_q == ST_LOAD);
    assign o_gen_enable    = o_gen_seed_load || (state_q == ST_RUN && more_bits);
    assign o_chk_clear     = o_gen_seed_load;  // checker relocks every test
    assign o_tx_valid      = (state_q == ST_RUN) && (sent_q != '0);  // seed itself not sent
    assign o_test_done     = done_q;

    ////////////////////////////////////////////////////////////
    // sequencer

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q        <= ST_IDLE;
            sent_q         <= '0;
            period_q       <= '0;
            period_found_q <= 1'b0;
            done_q         <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (i_start) begin  // start only seen here
                        state_q <= ST_LOAD;
                    end
                end
                ST_LOAD: begin
                    sent_q         <= '0;
                    period_q       <= '0;
                    period_found_q <= 1'b0;
                    state_q        <= ST_RUN;
                end
                ST_RUN: begin
                    if (more_bits) begin
                        sent_q <= sent_q + 1'b1;
                    end else begin
                        state_q <= ST_IDLE;  // last bit is on the line now
                        done_q  <= 1'b1;
                    end
                    // first return to seed after bit sent_q
                    if (o_tx_valid && i_lfsr_done && !period_found_q) begin
                        period_q       <= sent_q;
                        period_found_q <= 1'b1;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_comb begin
        o_status.busy      = busy;
        o_status.locked    = i_locked;
        o_status.err_count = i_err_count;
        o_status.period    = period_q;  // stays 0 without a wrap
    end

    ////////////////////////////////////////////////////////////
    // checks

    a_valid_only_busy : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_tx_valid |-> o_status.busy
    );

    a_done_single : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_test_done |=> !o_test_done
    );

endmodule : prbs_bist_ctrl

// File: src/prbs_checker.sv
`timescale 1ns/1ns

// self-synchronizing prbs checker
// fills a window from the first WIDTH rx bits, seeds a local lfsr, then free runs
module prbs_checker #(
    parameter int WIDTH = 8
) (
    input  logic                                      i_clk,
    input  logic                                      i_rst_n,
    input  logic                                      i_clear,     // new test, relock
    input  logic                                      i_rx_bit,
    input  logic                                      i_rx_valid,
    input  lfsr_taps_pkg::tap_vec_t                   i_taps,
    output logic                                      o_locked,
    output logic [prbs_bist_pkg::ERR_COUNT_WIDTH-1:0] o_err_count
);

    localparam int FILL_W = $clog2(WIDTH + 1);
    localparam int ERR_W  = prbs_bist_pkg::ERR_COUNT_WIDTH;

    logic [WIDTH-1:0]  win_q;        // rx window, newest bit at 0
    logic [WIDTH-1:0]  win_next;
    logic [FILL_W-1:0] fill_q;       // valid bits seen before lock
    logic              locked_q;
    logic              lock_now;     // window complete this cycle
    logic              lfsr_enable;
    logic [WIDTH-1:0]  local_state;
    logic              cmp_pend_q;   // compare rx_bit_q with new lfsr bit 0
    logic              rx_bit_q;
    logic [ERR_W-1:0]  err_q;
    logic              mismatch;

    ////////////////////////////////////////////////////////////
    // lock detection

    assign win_next = {win_q[WIDTH-2:0], i_rx_bit};
    assign lock_now = !i_clear && i_rx_valid && !locked_q
                    && (fill_q == FILL_W'(WIDTH - 1));

    // after lock the local lfsr steps once per valid bit, rx data never fed back
    assign lfsr_enable = lock_now || (!i_clear && locked_q && i_rx_valid);

    shifter_lfsr #(
        .WIDTH           (WIDTH),
        .TAP_INDEX_WIDTH (lfsr_taps_pkg::TAP_INDEX_WIDTH),
        .TAP_COUNT       (lfsr_taps_pkg::TAP_COUNT)
    ) local_lfsr_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_enable    (lfsr_enable),
        .i_seed_load (lock_now),
        .i_seed_data (win_next),     // full window incl. the current bit
        .i_taps      (i_taps),
        .o_lfsr_out  (local_state),
        .o_lfsr_done ()              // wrap not of interest on the rx side
    );

    // window and delayed rx bit
    always_ff @(posedge i_clk) begin
        if (i_rx_valid && !locked_q) begin
            win_q <= win_next;
        end
        rx_bit_q <= i_rx_bit;
    end

    ////////////////////////////////////////////////////////////
    // compare and count

    assign mismatch = cmp_pend_q && (rx_bit_q != local_state[0]);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            fill_q     <= '0;
            locked_q   <= 1'b0;
            cmp_pend_q <= 1'b0;
            err_q      <= '0;
        end else if (i_clear) begin
            fill_q     <= '0;
            locked_q   <= 1'b0;
            cmp_pend_q <= 1'b0;
            err_q      <= '0;
        end else begin
            cmp_pend_q <= locked_q && i_rx_valid;  // lfsr shifts with this bit
            if (i_rx_valid && !locked_q) begin
                fill_q <= fill_q + 1'b1;
            end
            if (lock_now) begin
                locked_q <= 1'b1;
            end
            if (mismatch && err_q != '1) begin
                err_q <= err_q + 1'b1;  // saturate at all ones
            end
        end
    end

    assign o_locked    = locked_q;
    assign o_err_count = err_q;

    // no error can be counted before the window is loaded
    a_no_count_unlocked : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !o_locked |=> $stable(o_err_count)
    );

endmodule : prbs_checker

// File: src/shifter_lfsr.sv
`timescale 1ns/1ns

// fibonacci lfsr, xnor feedback, taps given at run time
module shifter_lfsr #(
    parameter int WIDTH           = 8,
    parameter int TAP_INDEX_WIDTH = 8,
    parameter int TAP_COUNT       = 4
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_enable,     // shift or load this cycle
    input  logic                    i_seed_load,  // load seed instead of shifting
    input  logic [WIDTH-1:0]        i_seed_data,
    input  lfsr_taps_pkg::tap_vec_t i_taps,       // packed 1-based positions
    output logic [WIDTH-1:0]        o_lfsr_out,
    output logic                    o_lfsr_done   // state back at the seed
);

    logic [WIDTH-1:0] lfsr_q;
    logic [WIDTH-1:0] tap_mask;  // bit n-1 set for tap position n
    logic             feedback;

    // tap vector layout must agree with the slot parameters
    if ($bits(lfsr_taps_pkg::tap_vec_t) != TAP_INDEX_WIDTH * TAP_COUNT) begin : g_tap_layout
        $error("shifter_lfsr tap vector does not match TAP_INDEX_WIDTH * TAP_COUNT");
    end

    ////////////////////////////////////////////////////////////
    // tap decode

    always_comb begin
        logic [TAP_INDEX_WIDTH-1:0] pos;
        tap_mask = '0;
        for (int i = 0; i < TAP_COUNT; i++) begin
            pos = i_taps[i*TAP_INDEX_WIDTH +: TAP_INDEX_WIDTH];
            // position 0 is an empty slot, out of range positions are dropped
            if (pos != '0 && int'(pos) <= WIDTH) begin
                tap_mask[int'(pos) - 1] = 1'b1;
            end
        end
    end

    assign feedback = ~^(lfsr_q & tap_mask);  // xnor of tapped bits

    ////////////////////////////////////////////////////////////
    // state register

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            lfsr_q <= '0;
        end else if (i_enable) begin
            if (i_seed_load) begin
                lfsr_q <= i_seed_data;
            end else begin
                lfsr_q <= {lfsr_q[WIDTH-2:0], feedback};  // oldest bit drops off the top
            end
        end
    end

    assign o_lfsr_out  = lfsr_q;
    assign o_lfsr_done = (lfsr_q == i_seed_data);  // also high right after a load

    // a load request from outside must come with enable or it is lost
    a_seed_needs_enable : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_seed_load |-> i_enable
    );

endmodule : shifter_lfsr

// File: src/prbs_bist_pkg.sv
package prbs_bist_pkg;

    ////////////////////////////////////////////////////////////
    // field widths

    localparam int MAX_RUN_BITS    = 20;  // run length and period counters
    localparam int SEED_WIDTH      = 32;  // only low WIDTH bits reach the lfsr
    localparam int ERR_COUNT_WIDTH = 16;  // checker error counter, saturating

    ////////////////////////////////////////////////////////////
    // test request

    // held stable by the host while busy
    typedef struct packed {
        logic [SEED_WIDTH-1:0]   seed;     // generator start state
        logic [MAX_RUN_BITS-1:0] run_len;  // number of bits to transmit
    } bist_cfg_t;

    ////////////////////////////////////////////////////////////
    // test status

    typedef struct packed {
        logic                       busy;       // load or run in progress
        logic                       locked;     // checker aligned to rx stream
        logic [ERR_COUNT_WIDTH-1:0] err_count;  // mismatches since lock
        logic [MAX_RUN_BITS-1:0]    period;     // 0 = no wrap seen in the run
    } bist_status_t;

endpackage : prbs_bist_pkg

// File: src/lfsr_taps_pkg.sv
package lfsr_taps_pkg;

    ////////////////////////////////////////////////////////////
    // tap vector layout

    localparam int TAP_INDEX_WIDTH = 8;  // positions up to 255
    localparam int TAP_COUNT       = 4;  // position 0 = unused slot

    typedef logic [TAP_INDEX_WIDTH-1:0]           tap_index_t;
    typedef logic [TAP_COUNT*TAP_INDEX_WIDTH-1:0] tap_vec_t;  // slot 0 in low byte

    // pack up to four positions, first argument lands in slot 0
    function automatic tap_vec_t pack_taps(
        input int t0,
        input int t1 = 0,
        input int t2 = 0,
        input int t3 = 0
    );
        return {tap_index_t'(t3), tap_index_t'(t2), tap_index_t'(t1), tap_index_t'(t0)};
    endfunction

    ////////////////////////////////////////////////////////////
    // maximal-length xnor taps, positions counted from 1

    function automatic tap_vec_t max_len_taps(input int width);
        case (width)
            3:  return pack_taps(3, 2);
            4:  return pack_taps(4, 3);
            5:  return pack_taps(5, 3);
            6:  return pack_taps(6, 5);
            7:  return pack_taps(7, 6);
            8:  return pack_taps(8, 6, 5, 4);
            9:  return pack_taps(9, 5);
            10: return pack_taps(10, 7);
            11: return pack_taps(11, 9);
            12: return pack_taps(12, 6, 4, 1);
            13: return pack_taps(13, 4, 3, 1);
            14: return pack_taps(14, 5, 3, 1);
            15: return pack_taps(15, 14);
            16: return pack_taps(16, 15, 13, 4);
            17: return pack_taps(17, 14);
            18: return pack_taps(18, 11);
            19: return pack_taps(19, 6, 2, 1);
            20: return pack_taps(20, 17);
            21: return pack_taps(21, 19);
            22: return pack_taps(22, 21);
            23: return pack_taps(23, 18);
            24: return pack_taps(24, 23, 22, 17);
            25: return pack_taps(25, 22);
            26: return pack_taps(26, 6, 2, 1);
            27: return pack_taps(27, 5, 2, 1);
            28: return pack_taps(28, 25);
            29: return pack_taps(29, 27);
            30: return pack_taps(30, 6, 4, 1);
            31: return pack_taps(31, 28);
            32: return pack_taps(32, 22, 2, 1);
            default: return '0;  // no entry, all slots unused
        endcase
    endfunction

endpackage : lfsr_taps_pkg
